// File: verilog/scale_pkg.sv
// --------------------
// Shared widths, latencies and payload types for the sample scaling pipeline
// Imported by every design module that needs a sample, tag or product type
// --------------------

package scale_pkg;

  // --------------------
  // Widths
  // --------------------

  // Samples, coefficients and scaled results share one width
  localparam int SAMPLE_W = 16;
  // Metadata tag carried beside each sample
  localparam int TAG_W = 8;
  // Full signed product keeps every bit of the multiply
  localparam int PROD_W = 2 * SAMPLE_W;

  // --------------------
  // Latencies
  // --------------------

  // Register stages inside the multiplier
  localparam int MUL_STAGES = 3;
  // Register stages after the shift and saturate logic
  localparam int OUT_STAGES = 1;
  // Input valid to output valid distance in cycles
  localparam int LATENCY = MUL_STAGES + OUT_STAGES;

  // Arithmetic right shift applied to the product before clamping
  localparam int SCALE_SHIFT = 8;

  // --------------------
  // Types
  // --------------------

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic        [TAG_W-1:0]    tag_t;
  typedef logic signed [PROD_W-1:0]   prod_t;

  // Clamp limits of a signed sample
  localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

  // Output bundle, 25 bits with the tag in the top byte
  typedef struct packed {
    tag_t    tag;
    sample_t result;
    logic    sat;
  } out_word_t;

endpackage

// File: verilog/delay_valid.sv
// --------------------
// Fixed-latency delay line for any packed payload, qualified by a valid
// Zero stages gives a combinational pass-through
// --------------------

`timescale 1ns/1ps

module delay_valid #(
  parameter int  NUM_STAGES = 0,
  parameter type payload_t  = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  payload_t in,
  output logic     out_valid,
  output payload_t out
);

  // Elaboration check on the stage count
  if (NUM_STAGES < 0) begin : gen_bad_num_stages
    $error("delay_valid NUM_STAGES must be at least 0");
  end

  // --------------------
  // Stage chains
  // --------------------

  // Index 0 is the input itself, index NUM_STAGES drives the output
  logic     [NUM_STAGES:0] stage_valid;
  payload_t [NUM_STAGES:0] stage_data;

  assign stage_valid[0] = in_valid;
  assign stage_data[0]  = in;

  for (genvar i = 1; i <= NUM_STAGES; i++) begin : gen_stages
    // Valid flop clears on reset so nothing stale leaks out
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        stage_valid[i] <= 1'b0;
      end else begin
        stage_valid[i] <= stage_valid[i-1];
      end
    end

    // Payload only moves when the stage before it holds a valid item
    always_ff @(posedge clk) begin
      if (stage_valid[i-1]) begin
        stage_data[i] <= stage_data[i-1];
      end
    end
  end

  assign out_valid = stage_valid[NUM_STAGES];
  assign out       = stage_data[NUM_STAGES];

  // --------------------
  // Checks
  // --------------------

  if (NUM_STAGES > 0) begin : gen_checks
    // The valid chain is a pure delay
    a_valid_delay : assert property (@(posedge clk) disable iff (!arst_n)
      1'b1 |-> ##NUM_STAGES (out_valid == $past(in_valid, NUM_STAGES)))
      else $error("delay_valid out_valid does not follow in_valid");

    // Each accepted item comes out unchanged after the full delay
    a_data_delay : assert property (@(posedge clk) disable iff (!arst_n)
      in_valid |-> ##NUM_STAGES (out_valid && (out == $past(in, NUM_STAGES))))
      else $error("delay_valid payload changed in flight");
  end

endmodule

// File: verilog/mult_pipe.sv
// --------------------
// Three-stage signed multiplier with a valid strobe riding alongside
// Produces the full-width product exactly MUL_STAGES cycles after in_valid
// --------------------

`timescale 1ns/1ps

module mult_pipe
  import scale_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    in_valid,
  input  sample_t in_sample,
  input  sample_t in_coef,
  output logic    prod_valid,
  output prod_t   prod
);

  // --------------------
  // Valid chain
  // --------------------

  // One valid flop per stage, all cleared on reset
  logic s1_valid;
  logic s2_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid   <= 1'b0;
      s2_valid   <= 1'b0;
      prod_valid <= 1'b0;
    end else begin
      s1_valid   <= in_valid;
      s2_valid   <= s1_valid;
      prod_valid <= s2_valid;
    end
  end

  // --------------------
  // Datapath
  // --------------------

  // Stage 1 registers the operands
  sample_t s1_sample;
  sample_t s1_coef;

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_sample <= in_sample;
      s1_coef   <= in_coef;
    end
  end

  // Stage 2 registers the product
  // Both operands are widened to the product type first so the
  // multiply is signed and keeps every bit
  prod_t s2_prod;

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_prod <= prod_t'(s1_sample) * prod_t'(s1_coef);
    end
  end

  // Stage 3 registers the product once more
  // This gives the multiplier output a clean flop for timing
  always_ff @(posedge clk) begin
    if (s2_valid) begin
      prod <= s2_prod;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Operand product as seen at the input, only used by the check below
  prod_t in_prod;

  assign in_prod = prod_t'(in_sample) * prod_t'(in_coef);

  // A valid product matches the operands sampled MUL_STAGES cycles earlier
  a_prod_value : assert property (@(posedge clk) disable iff (!arst_n)
    prod_valid |-> (prod == $past(in_prod, MUL_STAGES)))
    else $error("mult_pipe product does not match delayed operands");

endmodule

// File: verilog/scale_sat.sv
// --------------------
// Shifts the product down, clamps it to sample width and flags saturation
// The packed result leaves through a one-stage delay line
// --------------------

`timescale 1ns/1ps

module scale_sat
  import scale_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      prod_valid,
  input  prod_t     prod,
  input  logic      tag_valid,
  input  tag_t      tag,
  output logic      out_valid,
  output out_word_t out_word
);

  // --------------------
  // Shift and clamp
  // --------------------

  // Arithmetic shift keeps the sign, so odd negatives round down
  prod_t shifted;

  assign shifted = prod >>> SCALE_SHIFT;

  logic      sat_hi;
  logic      sat_lo;
  sample_t   result;
  out_word_t word_next;

  always_comb begin
    // Limits are sign-extended to product width before comparing
    sat_hi = shifted > prod_t'(SAMPLE_MAX);
    sat_lo = shifted < prod_t'(SAMPLE_MIN);

    if (sat_hi) begin
      result = SAMPLE_MAX;
    end else if (sat_lo) begin
      result = SAMPLE_MIN;
    end else begin
      // In range, so the low bits already hold the right signed value
      result = shifted[SAMPLE_W-1:0];
    end

    word_next.tag    = tag;
    word_next.result = result;
    word_next.sat    = sat_hi | sat_lo;
  end

  // --------------------
  // Output register
  // --------------------

  // The whole word is one payload, so tag, result and flag stay aligned
  delay_valid #(
    .NUM_STAGES (OUT_STAGES),
    .payload_t  (out_word_t)
  ) u_out_delay (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (prod_valid),
    .in        (word_next),
    .out_valid (out_valid),
    .out       (out_word)
  );

  // --------------------
  // Checks
  // --------------------

  // The tag line and the multiplier must agree on which cycles are valid
  a_tag_aligned : assert property (@(posedge clk) disable iff (!arst_n)
    tag_valid == prod_valid)
    else $error("scale_sat tag valid out of step with product valid");

  // A flagged output always sits on one of the two clamp limits
  a_sat_limit : assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_word.sat) |->
      ((out_word.result == SAMPLE_MAX) || (out_word.result == SAMPLE_MIN)))
    else $error("scale_sat flag set on an unclamped result");

endmodule

// File: verilog/scale_pipe_top.sv
// --------------------
// Top of the scaling pipeline, multiplier and tag delay feeding the clamp
// Fixed latency of LATENCY cycles with no back-pressure
// --------------------

`timescale 1ns/1ps

module scale_pipe_top
  import scale_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    in_valid,
  input  sample_t in_sample,
  input  sample_t in_coef,
  input  tag_t    in_tag,
  output logic    out_valid,
  output tag_t    out_tag,
  output sample_t out_result,
  output logic    out_sat
);

  // Multiplier outputs
  logic      prod_valid;
  prod_t     prod;

  // Tag delayed to line up with the product
  logic      tag_valid;
  tag_t      tag_d;

  // Registered output bundle
  out_word_t out_word;

  // --------------------
  // Multiplier
  // --------------------

  mult_pipe u_mult (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .in_coef    (in_coef),
    .prod_valid (prod_valid),
    .prod       (prod)
  );

  // The tag takes the same number of stages as the multiplier
  delay_valid #(
    .NUM_STAGES (MUL_STAGES),
    .payload_t  (tag_t)
  ) u_tag_delay (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in        (in_tag),
    .out_valid (tag_valid),
    .out       (tag_d)
  );

  // --------------------
  // Saturation stage
  // --------------------

  scale_sat u_sat (
    .clk        (clk),
    .arst_n     (arst_n),
    .prod_valid (prod_valid),
    .prod       (prod),
    .tag_valid  (tag_valid),
    .tag        (tag_d),
    .out_valid  (out_valid),
    .out_word   (out_word)
  );

  // Split the bundle onto the loose output ports
  assign out_tag    = out_word.tag;
  assign out_result = out_word.result;
  assign out_sat    = out_word.sat;

endmodule

// File: tests/scale_pipe_tasks.svh
// --------------------
// Drive, wait and compare helpers, included into the testbench module
// --------------------

`ifndef SCALE_PIPE_TASKS_SVH
`define SCALE_PIPE_TASKS_SVH

// --------------------
// Compare
// --------------------

// Whole output word, printed field by field on a mismatch
task automatic check_word(input string name, input out_word_t exp, input out_word_t act);
  if (exp !== act) begin
    $display("** Error at %0t: %s expected tag %h result %0d sat %b, got tag %h result %0d sat %b",
             $time, name, exp.tag, exp.result, exp.sat, act.tag, act.result, act.sat);
    error_count++;
  end
endtask

// Single control bit such as out_valid
task automatic check_bit(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    error_count++;
  end
endtask

// --------------------
// Drive
// --------------------

// One valid sample, launched on the next rising edge
task automatic drive_sample(input sample_t sample, input sample_t coef, input tag_t tag);
  @(posedge clk);
  in_valid  <= 1'b1;
  in_sample <= sample;
  in_coef   <= coef;
  in_tag    <= tag;
endtask

// Holds the strobe low for a number of cycles
task automatic drive_idle(input int cycles);
  repeat (cycles) begin
    @(posedge clk);
    in_valid <= 1'b0;
  end
endtask

// --------------------
// Wait
// --------------------

// Waits until the monitor has seen every owed output
// The queue is read on the falling edge, well away from the monitor's updates
task automatic wait_drain(input int limit);
  int waited;
  waited = 0;
  while (due_q.size() != 0 && waited < limit) begin
    @(negedge clk);
    waited++;
  end
  if (due_q.size() != 0) begin
    $display("Timed out after %0d cycles with %0d outputs still owed", limit, due_q.size());
    error_count++;
    due_q.delete();
    exp_q.delete();
  end
endtask

// One summary line per test
task automatic finish_test(input string name, input int start);
  if (error_count == start) begin
    $display("PASS  %s", name);
    tests_passed++;
  end else begin
    $display("FAIL  %s with %0d errors", name, error_count - start);
    tests_failed++;
  end
endtask

`endif

// File: tests/scale_pipe_tb.sv
// --------------------
// Directed and random testbench for the scaling pipeline
// A monitor checks every output against a queue of model results
// --------------------

`timescale 1ns/1ps

module scale_pipe_tb
  import scale_pkg::*;
();

  logic    clk;
  logic    arst_n;
  logic    in_valid;
  sample_t in_sample;
  sample_t in_coef;
  tag_t    in_tag;
  logic    out_valid;
  tag_t    out_tag;
  sample_t out_result;
  logic    out_sat;

  // Expected words and the monitor cycle in which each is due
  int        due_q[$];
  out_word_t exp_q[$];
  int        cycle;
  int        error_count;
  int        tests_passed;
  int        tests_failed;

  always #5 clk = ~clk;

  scale_pipe_top u_scale_pipe_top (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .in_coef    (in_coef),
    .in_tag     (in_tag),
    .out_valid  (out_valid),
    .out_tag    (out_tag),
    .out_result (out_result),
    .out_sat    (out_sat)
  );

  `include "scale_pipe_tasks.svh"

  // --------------------
  // Reference model
  // --------------------

  // Product shifted right by SCALE_SHIFT, then clamped to the signed 16-bit range
  function automatic out_word_t expected_word(input sample_t sample, input sample_t coef,
                                              input tag_t tag);
    longint    product;
    longint    shifted;
    out_word_t word;
    product  = longint'(sample) * longint'(coef);
    shifted  = product >>> SCALE_SHIFT;
    word.tag = tag;
    if (shifted > 32767) begin
      word.result = 16'sh7fff;
      word.sat    = 1'b1;
    end else if (shifted < -32768) begin
      word.result = 16'sh8000;
      word.sat    = 1'b1;
    end else begin
      word.result = shifted[15:0];
      word.sat    = 1'b0;
    end
    return word;
  endfunction

  // Samples inputs and outputs on each rising edge, before the DUT flops update
  always @(posedge clk) begin
    if (!arst_n) begin
      // The first edge can still show power-up values
      if (cycle > 0) begin
        check_bit("out_valid in reset", 1'b0, out_valid);
      end
      due_q.delete();
      exp_q.delete();
    end else begin
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        check_bit("out_valid", 1'b1, out_valid);
        if (out_valid) begin
          check_word("out_word", exp_q[0], {out_tag, out_result, out_sat});
        end
        void'(due_q.pop_front());
        void'(exp_q.pop_front());
      end else if (out_valid) begin
        $display("Unexpected output at %0t: out_valid high with nothing due", $time);
        error_count++;
      end
      if (in_valid) begin
        due_q.push_back(cycle + LATENCY);
        exp_q.push_back(expected_word(in_sample, in_coef, in_tag));
      end
    end
    cycle++;
  end

  // --------------------
  // Tests
  // --------------------

  task automatic test_single();
    int start;
    int waited;
    start  = error_count;
    waited = 0;
    drive_sample(16'sd1000, 16'sd512, 8'h11);
    drive_idle(1);
    do begin
      @(negedge clk);
      waited++;
    end while (!out_valid && waited < 20);
    if (waited != LATENCY) begin
      $display("out_valid came %0d cycles after the strobe instead of %0d", waited, LATENCY);
      error_count++;
    end
    check_word("out_word", '{tag: 8'h11, result: 16'sd2000, sat: 1'b0},
               {out_tag, out_result, out_sat});
    @(negedge clk);
    check_bit("out_valid one cycle later", 1'b0, out_valid);
    wait_drain(10);
    finish_test("single sample", start);
  endtask

  // Eight strobes in a row keep four items in flight at once
  task automatic test_stream();
    int start;
    start = error_count;
    for (int i = 0; i < 8; i++) begin
      drive_sample(sample_t'(100 * (i + 1)), 16'sd256, tag_t'(8'h20 + i));
    end
    drive_idle(1);
    wait_drain(20);
    finish_test("back-to-back stream", start);
  endtask

  task automatic test_saturation();
    int start;
    start = error_count;
    drive_sample(16'sd32767, 16'sd32767, 8'h31);
    drive_sample(16'sh8000, 16'sd32767, 8'h32);
    // Odd negative shifted down gives -1, not 0
    drive_sample(-16'sd3, 16'sd1, 8'h33);
    drive_idle(1);
    wait_drain(20);
    finish_test("saturation", start);
  endtask

  task automatic test_random();
    int          start;
    int unsigned r;
    start = error_count;
    for (int i = 0; i < 200; i++) begin
      r = $urandom;
      @(posedge clk);
      in_valid  <= ($urandom_range(99) < 60);
      in_sample <= r[15:0];
      in_coef   <= r[31:16];
      in_tag    <= tag_t'($urandom);
    end
    drive_idle(1);
    wait_drain(20);
    finish_test("random traffic", start);
  endtask

  // Items in flight are dropped, the monitor flags any that leak out
  task automatic test_reset();
    int start;
    start = error_count;
    for (int i = 0; i < 3; i++) begin
      drive_sample(16'sd4000, sample_t'(300 + i), tag_t'(8'h40 + i));
    end
    @(posedge clk);
    in_valid <= 1'b0;
    arst_n   <= 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    drive_idle(6);
    drive_sample(-16'sd200, 16'sd768, 8'h5a);
    drive_idle(1);
    wait_drain(10);
    finish_test("reset mid-stream", start);
  endtask

  initial begin
    void'($urandom(32'h9d82));
    clk          = 1'b0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_sample    = '0;
    in_coef      = '0;
    in_tag       = '0;
    cycle        = 0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    drive_idle(2);
    test_single();
    test_stream();
    test_saturation();
    test_random();
    test_reset();
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+tests
verilog/scale_pkg.sv
verilog/delay_valid.sv
verilog/mult_pipe.sv
verilog/scale_sat.sv
verilog/scale_pipe_top.sv
tests/scale_pipe_tb.sv

// File: Makefile
# Verilator build and regression run for the scaling pipeline

TOP := scale_pipe_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
